/* design/mdu_pkg.sv */
package mdu_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [5:0]  rob_id_t;
    typedef logic [2:0]  mdu_op_t;

    // funct3 order, bit 2 selects the divider
    localparam mdu_op_t OP_MUL    = 3'd0;
    localparam mdu_op_t OP_MULH   = 3'd1;
    localparam mdu_op_t OP_MULHSU = 3'd2;
    localparam mdu_op_t OP_MULHU  = 3'd3;
    localparam mdu_op_t OP_DIV    = 3'd4;
    localparam mdu_op_t OP_DIVU   = 3'd5;
    localparam mdu_op_t OP_REM    = 3'd6;
    localparam mdu_op_t OP_REMU   = 3'd7;

    // tag is meaningful while not ready, value once ready
    typedef struct packed {
        logic    ready;
        rob_id_t tag;
        word_t   value;
    } src_t;

    typedef struct packed {
        mdu_op_t    op;
        rob_id_t    rob_id;
        src_t [1:0] src;
    } mdu_dispatch_t;

    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        word_t   data;
    } cdb_t;

    typedef struct packed {
        mdu_op_t op;
        rob_id_t rob_id;
        word_t   a;
        word_t   b;
    } mdu_req_t;

    typedef struct packed {
        rob_id_t rob_id;
        word_t   data;
    } mdu_res_t;

endpackage

/* design/mdu_iq_entry.sv */
`timescale 1ns/1ps

module mdu_iq_entry import mdu_pkg::*; #(
    parameter int CDB_COUNT = 2
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  logic                          init_i,
    input  mdu_dispatch_t                 disp_i,
    input  logic                          issue_i,
    input  cdb_t          [CDB_COUNT-1:0] cdb_i,
    output logic                          busy_o,
    output logic                          complete_o,
    output mdu_dispatch_t                 entry_o
);

    logic          busy_q;
    mdu_dispatch_t entry_q;
    mdu_dispatch_t entry_d;

    // ------------------------------------------------------------------------
    // operand snoop
    // ------------------------------------------------------------------------

    // start from the new instruction on init, so a broadcast in the
    // dispatch cycle is merged before the entry is written
    always_comb begin
        entry_d = init_i ? disp_i : entry_q;
        for (int s = 0; s < 2; s++) begin
            for (int c = 0; c < CDB_COUNT; c++) begin
                if (!entry_d.src[s].ready && cdb_i[c].valid
                        && cdb_i[c].rob_id == entry_d.src[s].tag) begin
                    entry_d.src[s].ready = 1'b1;
                    entry_d.src[s].value = cdb_i[c].data;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
        end else if (init_i) begin
            busy_q <= 1'b1;
        end else if (issue_i) begin
            busy_q <= 1'b0;
        end
    end

    // payload only moves while the slot is in use
    always_ff @(posedge clk) begin
        if (init_i || busy_q) begin
            entry_q <= entry_d;
        end
    end

    assign busy_o     = busy_q;
    assign complete_o = busy_q && entry_q.src[0].ready && entry_q.src[1].ready;
    assign entry_o    = entry_q;

endmodule

/* design/mdu_iq.sv */
`timescale 1ns/1ps

module mdu_iq import mdu_pkg::*; #(
    parameter int IQ_SIZE   = 8,
    parameter int CDB_COUNT = 2
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  mdu_dispatch_t [1:0]           disp_i,
    input  logic          [1:0]           choose_i,
    input  cdb_t          [CDB_COUNT-1:0] cdb_i,
    input  logic                          req_ready_i,
    output logic                          disp_ready_o,
    output logic                          req_valid_o,
    output mdu_req_t                      req_o
);

    localparam int PTR_LEN = $clog2(IQ_SIZE);

    typedef logic [PTR_LEN-1:0] ptr_t;
    typedef logic [PTR_LEN:0]   cnt_t;

    ptr_t          head_q;
    ptr_t          tail_q;
    ptr_t          tail_next;
    cnt_t          free_q;
    cnt_t          free_d;
    cnt_t          n_alloc;
    logic [1:0]    accept;
    logic          can_load;
    logic          do_issue;
    logic          req_valid_q;
    mdu_req_t      req_q;
    mdu_dispatch_t first_slot;
    mdu_dispatch_t head_entry;

    logic          [IQ_SIZE-1:0] entry_init;
    logic          [IQ_SIZE-1:0] entry_issue;
    logic          [IQ_SIZE-1:0] entry_busy;
    logic          [IQ_SIZE-1:0] entry_complete;
    mdu_dispatch_t               entry_disp [IQ_SIZE];
    mdu_dispatch_t               entry_held [IQ_SIZE];

    // ------------------------------------------------------------------------
    // allocation
    // ------------------------------------------------------------------------

    // choose strobes only count while the registered ready is up
    assign accept     = choose_i & {2{disp_ready_o}};
    assign n_alloc    = cnt_t'(accept[0]) + cnt_t'(accept[1]);
    assign tail_next  = tail_q + ptr_t'(1);
    // a lone slot 1 still lands on the tail
    assign first_slot = accept[0] ? disp_i[0] : disp_i[1];

    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            entry_disp[i] = (ptr_t'(i) == tail_next) ? disp_i[1] : first_slot;
            entry_init[i] = !entry_busy[i]
                            && (((|accept) && ptr_t'(i) == tail_q)
                                || ((&accept) && ptr_t'(i) == tail_next));
        end
    end

    // ------------------------------------------------------------------------
    // in-order issue from the head
    // ------------------------------------------------------------------------

    assign head_entry = entry_held[head_q];
    assign can_load   = !req_valid_q || req_ready_i;
    assign do_issue   = entry_complete[head_q] && can_load;

    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            entry_issue[i] = do_issue && ptr_t'(i) == head_q;
        end
    end

    // issue frees its slot in the same cycle
    assign free_d = free_q - n_alloc + cnt_t'(do_issue);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q       <= '0;
            tail_q       <= '0;
            free_q       <= cnt_t'(IQ_SIZE);
            disp_ready_o <= 1'b1;
            req_valid_q  <= 1'b0;
        end else if (flush_i) begin
            head_q       <= '0;
            tail_q       <= '0;
            free_q       <= cnt_t'(IQ_SIZE);
            disp_ready_o <= 1'b1;
            req_valid_q  <= 1'b0;
        end else begin
            head_q       <= head_q + ptr_t'(do_issue);
            tail_q       <= tail_q + ptr_t'(n_alloc);
            free_q       <= free_d;
            // room for a dual dispatch next cycle
            disp_ready_o <= free_d >= cnt_t'(2);
            if (can_load) begin
                req_valid_q <= do_issue;
            end
        end
    end

    // issue register payload
    always_ff @(posedge clk) begin
        if (do_issue) begin
            req_q.op     <= head_entry.op;
            req_q.rob_id <= head_entry.rob_id;
            req_q.a      <= head_entry.src[0].value;
            req_q.b      <= head_entry.src[1].value;
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_o       = req_q;

    // ------------------------------------------------------------------------
    // entries
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        mdu_iq_entry #(
            .CDB_COUNT(CDB_COUNT)
        ) u_entry (
            .clk        (clk),
            .arst_n_i   (arst_n_i),
            .flush_i    (flush_i),
            .init_i     (entry_init[i]),
            .disp_i     (entry_disp[i]),
            .issue_i    (entry_issue[i]),
            .cdb_i      (cdb_i),
            .busy_o     (entry_busy[i]),
            .complete_o (entry_complete[i]),
            .entry_o    (entry_held[i])
        );
    end

endmodule

/* design/mdu_unit.sv */
`timescale 1ns/1ps

module mdu_unit import mdu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     flush_i,
    input  logic     req_valid_i,
    input  mdu_req_t req_i,
    input  logic     res_ready_i,
    output logic     req_ready_o,
    output logic     res_valid_o,
    output mdu_res_t res_o
);

    typedef enum logic [1:0] {
        IDLE,
        MUL,
        DIV,
        DONE
    } state_t;

    // last step count in each busy state
    localparam logic [5:0] MUL_LAST = 6'd1;
    localparam logic [5:0] DIV_LAST = 6'd32;

    state_t              state_q;
    logic         [5:0]  cnt_q;
    logic                accept;
    logic                a_signed;
    logic                b_signed;
    logic                a_neg;
    logic                b_neg;
    mdu_op_t             op_q;
    rob_id_t             rob_q;
    word_t               dividend_q;
    word_t               result_q;
    logic signed  [32:0] mul_a_q;
    logic signed  [32:0] mul_b_q;
    logic signed  [65:0] prod_q;
    word_t               quo_q;
    word_t               rem_q;
    word_t               dvs_q;
    logic                neg_quo_q;
    logic                neg_rem_q;
    logic         [32:0] shifted;
    logic         [33:0] diff;
    word_t               quo_fix;
    word_t               rem_fix;

    assign accept = req_valid_i && state_q == IDLE;

    // operand signedness per op
    assign a_signed = req_i.op[2] ? !req_i.op[0] : (req_i.op != OP_MULHU);
    assign b_signed = req_i.op[2] ? !req_i.op[0]
                                  : (req_i.op == OP_MULH || req_i.op == OP_MUL);
    assign a_neg    = a_signed && req_i.a[31];
    assign b_neg    = b_signed && req_i.b[31];

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (flush_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (req_valid_i) begin
                        state_q <= req_i.op[2] ? DIV : MUL;
                    end
                end
                MUL: begin
                    cnt_q <= cnt_q + 6'd1;
                    if (cnt_q == MUL_LAST) begin
                        state_q <= DONE;
                    end
                end
                DIV: begin
                    cnt_q <= cnt_q + 6'd1;
                    if (cnt_q == DIV_LAST) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (res_ready_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------

    // one restoring step, 34 bits so the borrow is never lost
    assign shifted = {rem_q, quo_q[31]};
    assign diff    = {1'b0, shifted} - {2'b00, dvs_q};

    // sign fix, then the divide-by-zero rule
    always_comb begin
        quo_fix = neg_quo_q ? -quo_q : quo_q;
        rem_fix = neg_rem_q ? -rem_q : rem_q;
        if (dvs_q == '0) begin
            quo_fix = '1;
            rem_fix = dividend_q;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= req_i.op;
            rob_q      <= req_i.rob_id;
            dividend_q <= req_i.a;
            mul_a_q    <= {a_neg, req_i.a};
            mul_b_q    <= {b_neg, req_i.b};
            // divider works on magnitudes
            quo_q      <= a_neg ? -req_i.a : req_i.a;
            dvs_q      <= b_neg ? -req_i.b : req_i.b;
            rem_q      <= '0;
            neg_quo_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;
        end else if (state_q == MUL) begin
            if (cnt_q != MUL_LAST) begin
                prod_q <= mul_a_q * mul_b_q;
            end else begin
                result_q <= (op_q == OP_MUL) ? prod_q[31:0] : prod_q[63:32];
            end
        end else if (state_q == DIV) begin
            if (cnt_q != DIV_LAST) begin
                rem_q <= diff[33] ? shifted[31:0] : diff[31:0];
                quo_q <= {quo_q[30:0], !diff[33]};
            end else begin
                result_q <= op_q[1] ? rem_fix : quo_fix;
            end
        end
    end

    assign req_ready_o  = state_q == IDLE;
    assign res_valid_o  = state_q == DONE;
    assign res_o.rob_id = rob_q;
    assign res_o.data   = result_q;

endmodule

/* design/mdu_top.sv */
`timescale 1ns/1ps

module mdu_top import mdu_pkg::*; #(
    parameter int IQ_SIZE   = 8,
    parameter int CDB_COUNT = 2
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  mdu_dispatch_t [1:0]           disp_i,
    input  logic          [1:0]           choose_i,
    output logic                          disp_ready_o,
    input  cdb_t          [CDB_COUNT-1:0] cdb_i,
    output logic                          res_valid_o,
    output mdu_res_t                      res_o,
    input  logic                          res_ready_i
);

    // request handshake between queue and unit
    logic     req_valid;
    logic     req_ready;
    mdu_req_t req;

    mdu_iq #(
        .IQ_SIZE   (IQ_SIZE),
        .CDB_COUNT (CDB_COUNT)
    ) u_iq (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .disp_i       (disp_i),
        .choose_i     (choose_i),
        .cdb_i        (cdb_i),
        .req_ready_i  (req_ready),
        .disp_ready_o (disp_ready_o),
        .req_valid_o  (req_valid),
        .req_o        (req)
    );

    mdu_unit u_unit (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .res_ready_i (res_ready_i),
        .req_ready_o (req_ready),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        arst_n_o = 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* test/mdu_top_properties.sv */
`timescale 1ns/1ps

module mdu_top_properties import mdu_pkg::*; #(
    parameter int PTR_W = 3
) (
    input logic             clk,
    input logic             arst_n_i,
    input logic             flush_i,
    input logic             disp_ready_o,
    input logic             res_valid_o,
    input logic             res_ready_i,
    input mdu_res_t         res_o,
    input logic [PTR_W-1:0] tail_i
);

    // result is held under back-pressure
    assert property (@(posedge clk) disable iff (!arst_n_i || flush_i)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o))
        else $error("result changed while stalled");

    // tail only moves when dispatch was allowed
    assert property (@(posedge clk) disable iff (!arst_n_i || flush_i)
        !disp_ready_o |=> tail_i == $past(tail_i))
        else $error("dispatch taken while not ready");

    assert property (@(posedge clk) !arst_n_i |-> !res_valid_o)
        else $error("result valid during reset");

endmodule

bind mdu_top mdu_top_properties #(
    .PTR_W($clog2(IQ_SIZE))
) u_props (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .disp_ready_o (disp_ready_o),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_o        (res_o),
    .tail_i       (u_iq.tail_q)
);

/* test/mdu_top_tb.sv */
`timescale 1ns/1ps

module mdu_top_tb import mdu_pkg::*;;

    localparam int IQ_SIZE   = 8;
    localparam int CDB_COUNT = 2;
    // upper bound on instructions over all tests
    localparam int N_INSTR    = 110;
    localparam int TIMEOUT_NS = (N_INSTR * 40 + 300) * 10;

    logic                          clk;
    logic                          arst_n_i;
    logic                          flush_i;
    mdu_dispatch_t [1:0]           disp_i;
    logic          [1:0]           choose_i;
    logic                          disp_ready_o;
    cdb_t          [CDB_COUNT-1:0] cdb_i;
    logic                          res_valid_o;
    mdu_res_t                      res_o;
    logic                          res_ready_i;

    integer   seed     = 32'h4015_cb1e;
    int       fail_cnt = 0;
    logic     bp_en    = 1'b0;
    rob_id_t  rob_cnt  = '0;
    rob_id_t  tag_cnt  = 6'h20;
    mdu_res_t exp_q[$];
    mdu_res_t exp_head;

    tb_clock_gen u_clk (
        .clk_o    (clk),
        .arst_n_o (arst_n_i)
    );

    mdu_top #(
        .IQ_SIZE   (IQ_SIZE),
        .CDB_COUNT (CDB_COUNT)
    ) DUT (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .disp_i       (disp_i),
        .choose_i     (choose_i),
        .disp_ready_o (disp_ready_o),
        .cdb_i        (cdb_i),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o),
        .res_ready_i  (res_ready_i)
    );

    // ------------------------------------------------------------------------
    // reference model and helpers
    // ------------------------------------------------------------------------

    function automatic word_t ref_result(mdu_op_t op, word_t a, word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic        [63:0] ua;
        logic        [63:0] ub;
        logic        [63:0] p;
        word_t              r;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        p  = '0;
        case (op)
            OP_MUL: begin
                p = sa * sb;
                r = p[31:0];
            end
            OP_MULH: begin
                p = sa * sb;
                r = p[63:32];
            end
            OP_MULHSU: begin
                p = sa * $signed(ub);
                r = p[63:32];
            end
            OP_MULHU: begin
                p = ua * ub;
                r = p[63:32];
            end
            OP_DIV: begin
                if (b == 0) r = '1;
                else if (a == 32'h8000_0000 && b == '1) r = a;
                else r = word_t'($signed(a) / $signed(b));
            end
            OP_DIVU: r = (b == 0) ? '1 : a / b;
            OP_REM: begin
                if (b == 0) r = a;
                else if (a == 32'h8000_0000 && b == '1) r = '0;
                else r = word_t'($signed(a) % $signed(b));
            end
            default: r = (b == 0) ? a : a % b;
        endcase
        return r;
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    // a waiting operand carries a wrong value so an early issue shows up
    function automatic mdu_dispatch_t make_instr(mdu_op_t op, rob_id_t rob, word_t a, word_t b,
                                                 logic a_rdy, logic b_rdy,
                                                 rob_id_t a_tag, rob_id_t b_tag);
        mdu_dispatch_t d;
        d.op           = op;
        d.rob_id       = rob;
        d.src[0].ready = a_rdy;
        d.src[0].tag   = a_tag;
        d.src[0].value = a_rdy ? a : ~a;
        d.src[1].ready = b_rdy;
        d.src[1].tag   = b_tag;
        d.src[1].value = b_rdy ? b : ~b;
        return d;
    endfunction

    task automatic stop_on_error();
        fail_cnt++;
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic dispatch_two(input mdu_dispatch_t d0, input word_t e0,
                                input mdu_dispatch_t d1, input word_t e1,
                                input logic [1:0] ch, input cdb_t [1:0] bc);
        while (disp_ready_o !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        disp_i[0] = d0;
        disp_i[1] = d1;
        choose_i  = ch;
        cdb_i     = bc;
        if (ch[0]) exp_q.push_back('{rob_id: d0.rob_id, data: e0});
        if (ch[1]) exp_q.push_back('{rob_id: d1.rob_id, data: e1});
        @(posedge clk);
        #1;
        choose_i = 2'b00;
        cdb_i    = '0;
    endtask

    task automatic send_ready_pair(input mdu_op_t op0, input word_t a0, input word_t b0,
                                   input mdu_op_t op1, input word_t a1, input word_t b1,
                                   input logic [1:0] ch);
        mdu_dispatch_t d0;
        mdu_dispatch_t d1;
        d0 = make_instr(op0, rob_cnt, a0, b0, 1'b1, 1'b1, '0, '0);
        d1 = make_instr(op1, rob_cnt + 6'd1, a1, b1, 1'b1, 1'b1, '0, '0);
        rob_cnt = rob_cnt + 6'd2;
        dispatch_two(d0, ref_result(op0, a0, b0), d1, ref_result(op1, a1, b1), ch, '0);
    endtask

    task automatic broadcast(input cdb_t [1:0] bc);
        cdb_i = bc;
        @(posedge clk);
        #1;
        cdb_i = '0;
    endtask

    task automatic drain_results();
        while (exp_q.size() != 0) @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------------------
    // compare, back-pressure and watchdog
    // ------------------------------------------------------------------------

    // sampled mid-cycle, where the handshake is settled
    always @(negedge clk) begin
        if (arst_n_i && !flush_i && res_valid_o && res_ready_i) begin
            assert (exp_q.size() != 0) else begin
                $display("result for rob id %h arrived with nothing pending", res_o.rob_id);
                stop_on_error();
            end
            exp_head = exp_q.pop_front();
            assert (res_o.rob_id == exp_head.rob_id) else begin
                $display("FAIL res_o.rob_id expected %h got %h",
                         exp_head.rob_id, res_o.rob_id);
                stop_on_error();
            end
            assert (res_o.data == exp_head.data) else begin
                $display("FAIL res_o.data expected %h got %h", exp_head.data, res_o.data);
                stop_on_error();
            end
        end
    end

    always @(posedge clk) begin
        #1;
        res_ready_i = !bp_en || (($random(seed) & 1) != 0);
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the results did not all arrive in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    initial begin
        word_t         r;
        word_t         a0;
        word_t         b0;
        word_t         a1;
        word_t         b1;
        mdu_op_t       op0;
        mdu_op_t       op1;
        logic [1:0]    ch;
        cdb_t [1:0]    bc;
        rob_id_t       t0;
        rob_id_t       t1;
        mdu_dispatch_t d0;
        mdu_dispatch_t d1;

        flush_i     = 1'b0;
        disp_i      = '0;
        choose_i    = 2'b00;
        cdb_i       = '0;
        res_ready_i = 1'b1;
        @(posedge arst_n_i);
        @(posedge clk);
        #1;

        // ready operands, random slot choice
        for (int i = 0; i < 16; i++) begin
            r   = rand_word();
            ch  = (r[7:6] == 2'b00) ? 2'b11 : r[7:6];
            // every op lands on a chosen slot twice
            op0 = mdu_op_t'(i);
            op1 = (ch == 2'b10) ? op0 : r[5:3];
            send_ready_pair(op0, rand_word(), rand_word(), op1, rand_word(), rand_word(), ch);
        end
        drain_results();

        // divide by zero and overflow corners
        for (int i = 4; i < 8; i++) begin
            send_ready_pair(mdu_op_t'(i), rand_word(), 32'h0,
                            mdu_op_t'(i), 32'h8000_0000, 32'hffff_ffff, 2'b11);
        end
        drain_results();

        // operands woken from the CDB, some in the dispatch cycle
        for (int i = 0; i < 8; i++) begin
            r   = rand_word();
            op0 = r[2:0];
            op1 = r[5:3];
            a0  = rand_word();
            b0  = rand_word();
            a1  = rand_word();
            b1  = rand_word();
            t0  = tag_cnt;
            t1  = tag_cnt + 6'd1;
            tag_cnt = tag_cnt + 6'd2;
            d0 = make_instr(op0, rob_cnt, a0, b0, 1'b0, 1'b1, t0, '0);
            d1 = make_instr(op1, rob_cnt + 6'd1, a1, b1, 1'b1, 1'b0, '0, t1);
            rob_cnt = rob_cnt + 6'd2;
            bc = '0;
            if (i % 2 == 0) bc[r[8]] = '{valid: 1'b1, rob_id: t0, data: a0};
            dispatch_two(d0, ref_result(op0, a0, b0), d1, ref_result(op1, a1, b1), 2'b11, bc);
            repeat (r[10:9]) begin
                @(posedge clk);
                #1;
            end
            bc = '0;
            bc[r[11]] = '{valid: 1'b1, rob_id: t1, data: b1};
            if (i % 2 != 0) bc[!r[11]] = '{valid: 1'b1, rob_id: t0, data: a0};
            broadcast(bc);
        end
        drain_results();

        // random back-pressure on the result port
        bp_en = 1'b1;
        for (int i = 0; i < 12; i++) begin
            r = rand_word();
            send_ready_pair(r[2:0], rand_word(), rand_word(),
                            r[5:3], rand_word(), rand_word(), 2'b11);
        end
        drain_results();
        bp_en = 1'b0;

        // fill the queue behind a blocked head
        a0 = rand_word();
        b0 = rand_word();
        t0 = tag_cnt;
        tag_cnt = tag_cnt + 6'd1;
        d0 = make_instr(OP_MUL, rob_cnt, a0, b0, 1'b0, 1'b1, t0, '0);
        d1 = make_instr(OP_DIVU, rob_cnt + 6'd1, b0, a0, 1'b1, 1'b1, '0, '0);
        rob_cnt = rob_cnt + 6'd2;
        dispatch_two(d0, ref_result(OP_MUL, a0, b0), d1, ref_result(OP_DIVU, b0, a0),
                     2'b11, '0);
        for (int i = 0; i < 3; i++) begin
            r = rand_word();
            send_ready_pair(r[2:0], rand_word(), rand_word(),
                            r[5:3], rand_word(), rand_word(), 2'b11);
        end
        assert (disp_ready_o === 1'b0) else begin
            $display("FAIL disp_ready_o expected %h got %h", 1'b0, disp_ready_o);
            stop_on_error();
        end
        // strobes while not ready must leave the queue alone
        d1 = make_instr(OP_MUL, rob_cnt, a0, b0, 1'b1, 1'b1, '0, '0);
        disp_i[0] = d1;
        disp_i[1] = d1;
        choose_i  = 2'b11;
        @(posedge clk);
        #1;
        choose_i = 2'b00;
        assert (disp_ready_o === 1'b0) else begin
            $display("FAIL disp_ready_o expected %h got %h", 1'b0, disp_ready_o);
            stop_on_error();
        end
        bc = '0;
        bc[1] = '{valid: 1'b1, rob_id: t0, data: a0};
        broadcast(bc);
        drain_results();

        // flush with work in flight and the queue nearly full
        for (int i = 0; i < 4; i++) begin
            send_ready_pair(OP_DIV, rand_word(), rand_word(), OP_REM, rand_word(),
                            rand_word(), 2'b11);
        end
        d0 = make_instr(OP_MULH, rob_cnt, a0, b0, 1'b0, 1'b0, tag_cnt, tag_cnt);
        rob_cnt = rob_cnt + 6'd1;
        dispatch_two(d0, ref_result(OP_MULH, a0, b0), d0, ref_result(OP_MULH, a0, b0),
                     2'b01, '0);
        repeat (5) @(posedge clk);
        #1;
        flush_i = 1'b1;
        exp_q.delete();
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        assert (disp_ready_o === 1'b1) else begin
            $display("FAIL disp_ready_o expected %h got %h", 1'b1, disp_ready_o);
            stop_on_error();
        end
        repeat (40) @(posedge clk);
        #1;
        for (int i = 0; i < 2; i++) begin
            r = rand_word();
            send_ready_pair(r[2:0], rand_word(), rand_word(),
                            r[5:3], rand_word(), rand_word(), 2'b11);
        end
        drain_results();

        if (fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
design/mdu_pkg.sv
design/mdu_iq_entry.sv
design/mdu_iq.sv
design/mdu_unit.sv
design/mdu_top.sv
test/tb_clock_gen.sv
test/mdu_top_properties.sv
test/mdu_top_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module mdu_top_tb \
    -Mdir obj_dir -o mdu_sim &&
./obj_dir/mdu_sim | grep "ALL TESTS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
